//--- hw/rob_alloc_decode.sv
`timescale 1ns/1ps

module rob_alloc_decode (
    input  logic                                 clock,
    input  logic                                 reset_n,
    input  rob_types_pkg::enq_req_t              enq0,
    input  rob_types_pkg::enq_req_t              enq1,
    input  logic                                 iq_can_alloc0,
    input  rob_types_pkg::wb_req_t               intwb,
    input  rob_types_pkg::wb_req_t               memwb,
    input  rob_types_pkg::flush_t                flush,
    input  rob_types_pkg::robid_t                deq_robid,
    output rob_types_pkg::robid_t                enq_robid,
    output logic                                 rob_can_enq,
    output logic [rob_cfg_pkg::rob_size-1:0]     enq_wen,
    output rob_types_pkg::entry_t                enq_data0,
    output rob_types_pkg::entry_t                enq_data1,
    output logic [rob_cfg_pkg::rob_size-1:0]     enq_slot1_sel,
    output logic [rob_cfg_pkg::rob_size-1:0]     wb_complete,
    output logic [rob_cfg_pkg::rob_size-1:0]     wb_skip
);
    import rob_cfg_pkg::*;
    import rob_types_pkg::*;

    robid_t               enq_ptr;
    logic [robid_w-1:0]   used_cnt;
    logic [robid_w-1:0]   free_cnt;
    logic [rob_idx_w-1:0] slot0;
    logic [rob_idx_w-1:0] slot1;
    logic [rob_idx_w-1:0] int_idx;
    logic [rob_idx_w-1:0] mem_idx;
    logic                 acc0;
    logic                 acc1;

    // occupancy from the pointers, the wrap flag keeps full apart from empty
    assign used_cnt    = enq_ptr - deq_robid;
    assign free_cnt    = robid_w'(rob_size) - used_cnt;
    assign rob_can_enq = (free_cnt >= robid_w'(2)) && !flush.active;
    assign enq_robid   = enq_ptr;

    assign acc0  = enq0.valid && iq_can_alloc0 && rob_can_enq;
    assign acc1  = enq1.valid && acc0;  // slot 1 only behind slot 0
    assign slot0 = enq_ptr[rob_idx_w-1:0];
    assign slot1 = slot0 + rob_idx_w'(1);

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            enq_ptr <= '0;
        end else if (flush.active) begin
            enq_ptr <= flush.robid + robid_w'(1);  // just behind the survivor
        end else begin
            enq_ptr <= enq_ptr + robid_w'(acc0) + robid_w'(acc1);
        end
    end

    // one-hot write enables, slot 1 data steered by its own select
    always_comb begin
        enq_wen       = '0;
        enq_slot1_sel = '0;
        for (int i = 0; i < rob_size; i++) begin
            if (acc0 && slot0 == rob_idx_w'(i)) begin
                enq_wen[i] = 1'b1;
            end
            if (acc1 && slot1 == rob_idx_w'(i)) begin
                enq_wen[i]       = 1'b1;
                enq_slot1_sel[i] = 1'b1;
            end
        end
    end

    always_comb begin
        enq_data0.pc         = enq0.pc;
        enq_data0.lrd        = enq0.lrd;
        enq_data0.prd        = enq0.prd;
        enq_data0.old_prd    = enq0.old_prd;
        enq_data0.need_to_wb = enq0.need_to_wb;
        enq_data1.pc         = enq1.pc;
        enq_data1.lrd        = enq1.lrd;
        enq_data1.prd        = enq1.prd;
        enq_data1.old_prd    = enq1.old_prd;
        enq_data1.need_to_wb = enq1.need_to_wb;
    end

    assign int_idx = intwb.robid[rob_idx_w-1:0];
    assign mem_idx = memwb.robid[rob_idx_w-1:0];

    // writeback decode, skip comes from the memory port alone
    always_comb begin
        for (int i = 0; i < rob_size; i++) begin
            wb_complete[i] = (intwb.valid && int_idx == rob_idx_w'(i))
                          || (memwb.valid && mem_idx == rob_idx_w'(i));
            wb_skip[i]     = memwb.valid && memwb.mmio && mem_idx == rob_idx_w'(i);
        end
    end

endmodule

//--- hw/rob_cfg_pkg.sv
package rob_cfg_pkg;

    // buffer depth, power of two so the slot index wraps by itself
    localparam int rob_size = 16;

    localparam int rob_idx_w = $clog2(rob_size);  // slot index
    localparam int robid_w   = rob_idx_w + 1;     // msb is the wrap flag

    // widths of the stored fields
    localparam int pc_w   = 32;
    localparam int lreg_w = 5;  // 32 architectural registers
    localparam int preg_w = 6;  // 64 physical registers

endpackage

//--- hw/rob_entry_array.sv
`timescale 1ns/1ps

module rob_entry_array (
    input  logic                                               clock,
    input  logic                                               reset_n,
    input  logic [rob_cfg_pkg::rob_size-1:0]                   enq_wen,
    input  logic [rob_cfg_pkg::rob_size-1:0]                   enq_slot1_sel,
    input  rob_types_pkg::entry_t                              enq_data0,
    input  rob_types_pkg::entry_t                              enq_data1,
    input  logic [rob_cfg_pkg::rob_size-1:0]                   wb_complete,
    input  logic [rob_cfg_pkg::rob_size-1:0]                   wb_skip,
    input  logic [rob_cfg_pkg::rob_size-1:0]                   commit_clr,
    input  logic [rob_cfg_pkg::rob_size-1:0]                   squash,
    output logic [rob_cfg_pkg::rob_size-1:0]                   entry_valid,
    output logic [rob_cfg_pkg::rob_size-1:0]                   entry_complete,
    output logic [rob_cfg_pkg::rob_size-1:0]                   entry_skip,
    output rob_types_pkg::entry_t [rob_cfg_pkg::rob_size-1:0]  entries
);
    import rob_cfg_pkg::*;
    import rob_types_pkg::*;

    for (genvar i = 0; i < rob_size; i++) begin : g_slot
        logic   valid_q;
        logic   complete_q;
        logic   skip_q;
        entry_t data_q;
        logic   kill;

        // the head leaving or a rollback both drop the slot
        assign kill = commit_clr[i] || squash[i];

        always_ff @(posedge clock or negedge reset_n) begin
            if (!reset_n) begin
                valid_q    <= 1'b0;
                complete_q <= 1'b0;
                skip_q     <= 1'b0;
            end else if (enq_wen[i]) begin
                valid_q    <= 1'b1;  // fresh instruction, nothing done yet
                complete_q <= 1'b0;
                skip_q     <= 1'b0;
            end else begin
                if (kill) begin
                    valid_q <= 1'b0;
                end
                // writebacks to a dead slot are dropped
                if (valid_q && wb_complete[i]) begin
                    complete_q <= 1'b1;
                end
                if (valid_q && wb_skip[i]) begin
                    skip_q <= 1'b1;
                end
            end
        end

        always_ff @(posedge clock) begin
            if (enq_wen[i]) begin
                data_q <= enq_slot1_sel[i] ? enq_data1 : enq_data0;
            end
        end

        assign entry_valid[i]    = valid_q;
        assign entry_complete[i] = complete_q;
        assign entry_skip[i]     = skip_q;
        assign entries[i]        = data_q;
    end

endmodule

//--- hw/rob_retire_ctrl.sv
`timescale 1ns/1ps

module rob_retire_ctrl (
    input  logic                                               clock,
    input  logic                                               reset_n,
    input  logic [rob_cfg_pkg::rob_size-1:0]                   entry_valid,
    input  logic [rob_cfg_pkg::rob_size-1:0]                   entry_complete,
    input  logic [rob_cfg_pkg::rob_size-1:0]                   entry_skip,
    input  rob_types_pkg::entry_t [rob_cfg_pkg::rob_size-1:0]  entries,
    input  logic                                               flush_valid,
    input  rob_types_pkg::robid_t                              flush_robid,
    output rob_types_pkg::commit_t                             commit,
    output logic [rob_cfg_pkg::rob_size-1:0]                   commit_clr,
    output logic [rob_cfg_pkg::rob_size-1:0]                   squash,
    output rob_types_pkg::flush_t                              flush,
    output rob_types_pkg::robid_t                              deq_robid,
    output rob_types_pkg::rob_state_e                          rob_state
);
    import rob_cfg_pkg::*;
    import rob_types_pkg::*;

    robid_t               deq_ptr;
    robid_t               flush_q;
    rob_state_e           state_q;
    rob_state_e           state_d;
    logic [rob_idx_w-1:0] head_idx;
    logic [robid_w-1:0]   flush_dist;
    logic [rob_idx_w-1:0] flush_age;
    logic                 flush_gone;
    logic                 commit_fire;

    assign head_idx  = deq_ptr[rob_idx_w-1:0];
    assign deq_robid = deq_ptr;

    // head retires once complete, never while rolling back
    assign commit_fire = entry_valid[head_idx] && entry_complete[head_idx]
                      && (state_q == IDLE);

    always_comb begin
        commit.valid = commit_fire;
        commit.robid = deq_ptr;
        commit.entry = entries[head_idx];
        commit.skip  = entry_skip[head_idx];
    end

    assign commit_clr = commit_fire ? (rob_size'(1) << head_idx) : '0;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            deq_ptr <= '0;
        end else begin
            deq_ptr <= deq_ptr + robid_w'(commit_fire);
        end
    end

    always_ff @(posedge clock) begin
        if (flush_valid) begin
            flush_q <= flush_robid;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (flush_valid) begin
                    state_d = ROLLBACK;
                end
            end
            ROLLBACK: begin
                if (!flush_valid) begin  // a new flush restarts rollback
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign rob_state    = state_q;
    assign flush.active = (state_q == ROLLBACK);
    assign flush.robid  = flush_q;

    // age counted from the head, so wrap needs no special case
    assign flush_dist = flush_q - deq_ptr;
    assign flush_age  = flush_dist[rob_idx_w-1:0];
    assign flush_gone = flush_dist[robid_w-1];  // survivor retired on the flush edge

    always_comb begin
        logic [rob_idx_w-1:0] age;
        squash = '0;
        for (int i = 0; i < rob_size; i++) begin
            age       = rob_idx_w'(i) - head_idx;
            squash[i] = flush.active && entry_valid[i]
                     && (flush_gone || (age > flush_age));
        end
    end

endmodule

//--- hw/rob_top.sv
`timescale 1ns/1ps

module rob_top (
    input  logic                              clock,
    input  logic                              reset_n,
    input  rob_types_pkg::enq_req_t           enq0,
    input  rob_types_pkg::enq_req_t           enq1,
    input  logic                              iq_can_alloc0,
    input  rob_types_pkg::wb_req_t            intwb,
    input  rob_types_pkg::wb_req_t            memwb,
    input  logic                              flush_valid,
    input  rob_types_pkg::robid_t             flush_robid,
    output logic                              rob_can_enq,
    output rob_types_pkg::robid_t             enq_robid,
    output rob_types_pkg::commit_t            commit,
    output rob_types_pkg::rob_state_e         rob_state
);
    import rob_cfg_pkg::*;
    import rob_types_pkg::*;

    // decode to array
    logic [rob_size-1:0]   enq_wen;
    logic [rob_size-1:0]   enq_slot1_sel;
    logic [rob_size-1:0]   wb_complete;
    logic [rob_size-1:0]   wb_skip;
    entry_t                enq_data0;
    entry_t                enq_data1;

    // array to retire
    logic [rob_size-1:0]   entry_valid;
    logic [rob_size-1:0]   entry_complete;
    logic [rob_size-1:0]   entry_skip;
    entry_t [rob_size-1:0] entries;

    // retire back to array and decode
    logic [rob_size-1:0]   commit_clr;
    logic [rob_size-1:0]   squash;
    flush_t                flush;
    robid_t                deq_robid;

    rob_alloc_decode u_alloc_decode (
        .clock         (clock),
        .reset_n       (reset_n),
        .enq0          (enq0),
        .enq1          (enq1),
        .iq_can_alloc0 (iq_can_alloc0),
        .intwb         (intwb),
        .memwb         (memwb),
        .flush         (flush),
        .deq_robid     (deq_robid),
        .enq_robid     (enq_robid),
        .rob_can_enq   (rob_can_enq),
        .enq_wen       (enq_wen),
        .enq_data0     (enq_data0),
        .enq_data1     (enq_data1),
        .enq_slot1_sel (enq_slot1_sel),
        .wb_complete   (wb_complete),
        .wb_skip       (wb_skip)
    );

    rob_entry_array u_entry_array (
        .clock          (clock),
        .reset_n        (reset_n),
        .enq_wen        (enq_wen),
        .enq_slot1_sel  (enq_slot1_sel),
        .enq_data0      (enq_data0),
        .enq_data1      (enq_data1),
        .wb_complete    (wb_complete),
        .wb_skip        (wb_skip),
        .commit_clr     (commit_clr),
        .squash         (squash),
        .entry_valid    (entry_valid),
        .entry_complete (entry_complete),
        .entry_skip     (entry_skip),
        .entries        (entries)
    );

    rob_retire_ctrl u_retire_ctrl (
        .clock          (clock),
        .reset_n        (reset_n),
        .entry_valid    (entry_valid),
        .entry_complete (entry_complete),
        .entry_skip     (entry_skip),
        .entries        (entries),
        .flush_valid    (flush_valid),
        .flush_robid    (flush_robid),
        .commit         (commit),
        .commit_clr     (commit_clr),
        .squash         (squash),
        .flush          (flush),
        .deq_robid      (deq_robid),
        .rob_state      (rob_state)
    );

endmodule

//--- hw/rob_types_pkg.sv
package rob_types_pkg;

    // slot index in the low bits, wrap flag on top
    typedef logic [rob_cfg_pkg::robid_w-1:0] robid_t;

    // one dispatch slot, in program order
    typedef struct packed {
        logic                             valid;
        logic [rob_cfg_pkg::pc_w-1:0]     pc;
        logic [rob_cfg_pkg::lreg_w-1:0]   lrd;
        logic [rob_cfg_pkg::preg_w-1:0]   prd;
        logic [rob_cfg_pkg::preg_w-1:0]   old_prd;  // freed at commit
        logic                             need_to_wb;
    } enq_req_t;

    typedef struct packed {
        logic   valid;
        robid_t robid;
        logic   mmio;  // memory port only
    } wb_req_t;

    // payload kept per slot
    typedef struct packed {
        logic [rob_cfg_pkg::pc_w-1:0]     pc;
        logic [rob_cfg_pkg::lreg_w-1:0]   lrd;
        logic [rob_cfg_pkg::preg_w-1:0]   prd;
        logic [rob_cfg_pkg::preg_w-1:0]   old_prd;
        logic                             need_to_wb;
    } entry_t;

    typedef struct packed {
        logic   valid;
        robid_t robid;
        entry_t entry;
        logic   skip;  // mmio access, not checked against a model
    } commit_t;

    // rollback command, retire to decode
    typedef struct packed {
        logic   active;
        robid_t robid;  // last surviving instruction
    } flush_t;

    typedef enum logic {
        IDLE,
        ROLLBACK
    } rob_state_e;

endpackage

//--- rob.f
hw/rob_cfg_pkg.sv
hw/rob_types_pkg.sv
hw/rob_alloc_decode.sv
hw/rob_entry_array.sv
hw/rob_retire_ctrl.sv
hw/rob_top.sv
tests/rob_sva.sv
tests/rob_checker.sv
tests/rob_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the reorder buffer testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module rob_tb -f rob.f -o rob_sim || exit 1

# the run counts as passing only when the pass line shows up
out="$(./obj_dir/rob_sim)"
echo "$out"
echo "$out" | grep -q "SIMULATION PASSED" && exit 0 || exit 1

//--- tests/rob_checker.sv
`timescale 1ns/1ps

module rob_checker (
    input  logic                       clock,
    input  logic                       reset_n,
    input  rob_types_pkg::commit_t     commit,
    input  logic                       rob_can_enq,
    input  rob_types_pkg::robid_t      enq_robid,
    input  rob_types_pkg::rob_state_e  rob_state
);
    import rob_types_pkg::*;

    commit_t exp_q[$];    // filled by the testbench model
    commit_t act_q[$];    // seen on the DUT port
    string   test_name   = "none";
    int      test_count  = 0;
    int      test_errors = 0;
    int      check_count = 0;
    int      error_count = 0;

    task automatic fail_value(string what, logic [63:0] expected, logic [63:0] actual);
        $display("** Error: %s: %s expected %h actual %h", test_name, what, expected, actual);
        test_errors++;
        error_count++;
    endtask

    task automatic fail_text(string msg);
        $display("error in %s: %s", test_name, msg);
        test_errors++;
        error_count++;
    endtask

    task automatic start_test(string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic expect_commit(commit_t c);
        exp_q.push_back(c);
    endtask

    function automatic int pending_count();
        return exp_q.size();
    endfunction

    task automatic check_status(string what, logic can_enq, robid_t robid,
                                rob_state_e state, logic commit_valid);
        logic [7:0] expected;
        logic [7:0] actual;
        expected = {can_enq, robid, state, commit_valid};
        actual   = {rob_can_enq, enq_robid, rob_state, commit.valid};
        check_count++;
        if (actual !== expected) begin
            fail_value({what, " {can_enq,robid,state,commit}"}, 64'(expected), 64'(actual));
        end
    endtask

    task automatic compare_commit(commit_t e, commit_t a);
        check_count++;
        if (a !== e) begin
            fail_value($sformatf("commit of robid %0d", e.robid), 64'(e), 64'(a));
        end
    endtask

    // commit only depends on registers, settled by the falling edge
    always @(negedge clock) begin
        if (reset_n && commit.valid) begin
            act_q.push_back(commit);
        end
        while (exp_q.size() > 0 && act_q.size() > 0) begin
            compare_commit(exp_q.pop_front(), act_q.pop_front());
        end
    end

    task automatic end_test();
        if (exp_q.size() > 0) begin
            fail_text($sformatf("%0d expected commits never appeared", exp_q.size()));
        end
        if (act_q.size() > 0) begin
            fail_text($sformatf("%0d commits appeared with no instruction behind them",
                                act_q.size()));
        end
        exp_q.delete();
        act_q.delete();
        test_count++;
        $display("test %s: %s, %0d errors", test_name,
                 (test_errors == 0) ? "ok" : "failing", test_errors);
    endtask

endmodule

//--- tests/rob_sva.sv
`timescale 1ns/1ps

module rob_sva (
    input  logic                       clock,
    input  logic                       reset_n,
    input  rob_types_pkg::commit_t     commit,
    input  rob_types_pkg::robid_t      deq_robid,
    input  logic                       flush_valid,
    input  rob_types_pkg::rob_state_e  rob_state
);
    import rob_types_pkg::*;

    // retirement waits until the squash is done
    no_commit_in_rollback: assert property (
        @(posedge clock) disable iff (!reset_n)
        rob_state == ROLLBACK |-> !commit.valid
    ) else $error("commit valid while rolling back");

    deq_steps_on_commit: assert property (
        @(posedge clock) disable iff (!reset_n)
        commit.valid |=> deq_robid == robid_t'($past(deq_robid) + 1'b1)
    ) else $error("dequeue robid did not advance by one on a commit");

    flush_enters_rollback: assert property (
        @(posedge clock) disable iff (!reset_n)
        flush_valid |=> rob_state == ROLLBACK
    ) else $error("flush was not followed by rollback");

endmodule

bind rob_retire_ctrl rob_sva sva0 (
    .clock       (clock),
    .reset_n     (reset_n),
    .commit      (commit),
    .deq_robid   (deq_robid),
    .flush_valid (flush_valid),
    .rob_state   (rob_state)
);

//--- tests/rob_tb.sv
`timescale 1ns/1ps

module rob_tb;
    import rob_types_pkg::*;

    // one instruction as the model tracks it
    typedef struct packed {
        robid_t robid;
        entry_t entry;
        logic   mmio;       // written back on memwb as mmio
        logic   written;
        logic   squashed;
    } rec_t;

    localparam int stim_cycles = 400;   // rough length of all tests
    localparam int drain_limit = 64;

    logic       clock;
    logic       reset_n;
    enq_req_t   enq0;
    enq_req_t   enq1;
    logic       iq_can_alloc0;
    wb_req_t    intwb;
    wb_req_t    memwb;
    logic       flush_valid;
    robid_t     flush_robid;
    logic       rob_can_enq;
    robid_t     enq_robid;
    commit_t    commit;
    rob_state_e rob_state;

    rec_t   rec_q[$];
    robid_t model_enq;

    rob_top dut0 (
        .clock         (clock),
        .reset_n       (reset_n),
        .enq0          (enq0),
        .enq1          (enq1),
        .iq_can_alloc0 (iq_can_alloc0),
        .intwb         (intwb),
        .memwb         (memwb),
        .flush_valid   (flush_valid),
        .flush_robid   (flush_robid),
        .rob_can_enq   (rob_can_enq),
        .enq_robid     (enq_robid),
        .commit        (commit),
        .rob_state     (rob_state)
    );

    rob_checker chk0 (
        .clock       (clock),
        .reset_n     (reset_n),
        .commit      (commit),
        .rob_can_enq (rob_can_enq),
        .enq_robid   (enq_robid),
        .rob_state   (rob_state)
    );

    initial clock = 1'b0;
    always #20 clock = ~clock;

    function automatic enq_req_t random_req();
        enq_req_t q;
        q.valid      = 1'b1;
        q.pc         = $urandom() & 32'hffff_fffc;  // word aligned
        q.lrd        = 5'($urandom());
        q.prd        = 6'($urandom());
        q.old_prd    = 6'($urandom());
        q.need_to_wb = 1'($urandom());
        return q;
    endfunction

    // what the DUT has to show when this instruction retires
    function automatic commit_t expected_commit(rec_t r);
        commit_t c;
        c.valid = r.written && !r.squashed;  // squashed ones never retire
        c.robid = r.robid;
        c.entry = r.entry;
        c.skip  = r.mmio;
        return c;
    endfunction

    task automatic add_record(enq_req_t q);
        rec_t r;
        r       = '0;
        r.robid = model_enq;
        r.entry = {q.pc, q.lrd, q.prd, q.old_prd, q.need_to_wb};
        rec_q.push_back(r);
        model_enq = model_enq + 1'b1;
    endtask

    // request held until rob_can_enq is seen at an edge
    task automatic enqueue(int n);
        enq_req_t a;
        enq_req_t b;
        logic     taken;
        a       = random_req();
        b       = random_req();
        b.valid = (n == 2);
        enq0    = a;
        enq1    = b;
        taken   = 1'b0;
        while (!taken) begin
            @(negedge clock);
            taken = rob_can_enq;
            @(posedge clock);
            #2;
        end
        enq0 = '0;
        enq1 = '0;
        add_record(a);
        if (n == 2) begin
            add_record(b);
        end
    endtask

    task automatic writeback(int k, logic on_mem, logic mmio);
        wb_req_t w;
        rec_t    r;
        r       = rec_q[k];
        w.valid = 1'b1;
        w.robid = r.robid;
        w.mmio  = mmio;
        if (on_mem) begin
            memwb = w;
        end else begin
            intwb = w;
        end
        @(posedge clock);
        #2;
        intwb     = '0;
        memwb     = '0;
        r.written = 1'b1;
        r.mmio    = on_mem && mmio;  // mmio bit on intwb means nothing
        rec_q[k]  = r;
    endtask

    // shuffled order, fixed port and mmio pattern when mix is set
    task automatic writeback_shuffled(logic mix);
        int   order[$];
        int   j;
        int   t;
        logic on_mem;
        logic mmio;
        foreach (rec_q[i]) begin
            if (!rec_q[i].squashed && !rec_q[i].written) begin
                order.push_back(i);
            end
        end
        for (int i = order.size() - 1; i > 0; i--) begin
            j        = $urandom_range(i, 0);
            t        = order[i];
            order[i] = order[j];
            order[j] = t;
        end
        foreach (order[i]) begin
            on_mem = mix ? ((order[i] % 2) == 0) : 1'($urandom());
            mmio   = mix && ((order[i] % 4) < 2);
            writeback(order[i], on_mem, mmio);
        end
    endtask

    task automatic publish_expected();
        commit_t c;
        foreach (rec_q[i]) begin
            c = expected_commit(rec_q[i]);
            if (c.valid) begin
                chk0.expect_commit(c);
            end
        end
        rec_q.delete();
    endtask

    // wait for the checker to see every published commit
    task automatic drain_expected();
        int waited;
        waited = 0;
        while (chk0.pending_count() > 0 && waited < drain_limit) begin
            @(posedge clock);
            #2;
            waited++;
        end
        repeat (2) @(posedge clock);  // room for a stray commit
        #2;
    endtask

    task automatic finish_test();
        publish_expected();
        drain_expected();
        chk0.end_test();
    endtask

    task automatic status_check(string what, logic can_enq, robid_t robid,
                                rob_state_e state, logic commit_valid);
        @(negedge clock);
        chk0.check_status(what, can_enq, robid, state, commit_valid);
        @(posedge clock);
        #2;
    endtask

    task automatic flush_round();
        int     fi;
        robid_t fr;
        robid_t old_enq;
        logic   younger;
        rec_t   r;
        for (int i = 0; i < 5; i++) begin
            enqueue(2);
        end
        // all but the head done, only the squash keeps the young ones back
        for (int i = 1; i < rec_q.size(); i++) begin
            writeback(i, 1'b0, 1'b0);
        end
        fi          = $urandom_range(7, 2);
        fr          = rec_q[fi].robid;
        old_enq     = model_enq;
        flush_valid = 1'b1;
        flush_robid = fr;
        @(posedge clock);
        #2;
        flush_valid = 1'b0;
        younger     = 1'b0;
        foreach (rec_q[i]) begin
            r          = rec_q[i];
            r.squashed = younger;
            rec_q[i]   = r;
            if (r.robid == fr) begin
                younger = 1'b1;
            end
        end
        model_enq = fr + 1'b1;
        // pointer moves back only at the end of the rollback cycle
        status_check("in rollback", 1'b0, old_enq, ROLLBACK, 1'b0);
        status_check("after rollback", 1'b1, model_enq, IDLE, 1'b0);
        writeback(0, 1'b0, 1'b0);  // survivors retire now
        publish_expected();
        drain_expected();
        enqueue(2);
        enqueue(2);
        writeback_shuffled(1'b0);
    endtask

    initial begin
        int waited;
        void'($urandom(32'hff20));
        reset_n       = 1'b0;
        enq0          = '0;
        enq1          = '0;
        iq_can_alloc0 = 1'b1;
        intwb         = '0;
        memwb         = '0;
        flush_valid   = 1'b0;
        flush_robid   = '0;
        model_enq     = '0;
        repeat (2) @(posedge clock);
        #2;
        reset_n = 1'b1;

        chk0.start_test("reset");
        status_check("after reset", 1'b1, '0, IDLE, 1'b0);
        finish_test();

        chk0.start_test("dual_random");
        repeat (3) begin
            for (int i = 0; i < 6; i++) begin
                enqueue(2);
            end
            writeback_shuffled(1'b0);
            publish_expected();
        end
        finish_test();

        chk0.start_test("fill");
        for (int i = 0; i < 7; i++) begin
            enqueue(2);
        end
        enqueue(1);  // one slot left
        status_check("one slot free", 1'b0, model_enq, IDLE, 1'b0);
        writeback(0, 1'b0, 1'b0);
        waited = 0;
        while (!rob_can_enq && waited < 8) begin
            @(posedge clock);
            #2;
            waited++;
        end
        status_check("after head commit", 1'b1, model_enq, IDLE, 1'b0);
        writeback_shuffled(1'b0);
        finish_test();

        chk0.start_test("mmio_skip");
        for (int i = 0; i < 4; i++) begin
            enqueue(2);
        end
        writeback_shuffled(1'b1);
        finish_test();

        for (int i = 0; i < 2; i++) begin
            chk0.start_test($sformatf("flush_%0d", i));
            flush_round();
            finish_test();
        end

        $display("tests %0d, checks %0d, errors %0d",
                 chk0.test_count, chk0.check_count, chk0.error_count);
        if (chk0.error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // bound of four times the expected run length
    initial begin
        #(stim_cycles * 40 * 4);
        $display("watchdog: tests did not end within %0d cycles, the DUT seems hung",
                 stim_cycles * 4);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule
